// File: include/line_swap_consts.svh
`ifndef LINE_SWAP_CONSTS_SVH
`define LINE_SWAP_CONSTS_SVH

// Active pixels per line kept small for simulation
`define LSB_H_ACT 16

`define LSB_COL_W 11
`define LSB_ROW_W 11
`define LSB_FLAG_W 4

// Idle cycles between camera 1 line end and camera 2 trigger
`define LSB_GAP_WAIT `LSB_H_ACT

`define LSB_CAM1_ID 5'b10000
`define LSB_CAM2_ID 5'b01000

`endif

// File: rtl/line_swap_pkg.sv
`include "line_swap_consts.svh"

package line_swap_pkg;

    typedef logic [23:0] pixel_t;                  // R in top byte, then G, B
    typedef logic [`LSB_FLAG_W-1:0] flags_t;       // Bit 0 marks a valid pixel
    typedef logic [`LSB_COL_W-1:0] col_t;
    typedef logic [`LSB_ROW_W-1:0] row_t;
    typedef logic [$bits(pixel_t)+`LSB_FLAG_W+`LSB_COL_W+`LSB_ROW_W-1:0] cam_pack_t;
    typedef logic [7:0] byte_t;
    typedef logic [4:0] cam_id_t;

    typedef enum logic [2:0] {
        IDLE,
        TRIG_CAM1,
        WAIT_CAM1,
        GAP,
        TRIG_CAM2,
        WAIT_CAM2
    } swap_state_t;

endpackage : line_swap_pkg

// File: rtl/line_buffer.sv
`timescale 1ns/1ps
`include "line_swap_consts.svh"

module line_buffer #(
    parameter int H_ACT = `LSB_H_ACT
) (
    input  logic                     rclk,
    input  logic                     rstn,
    input  line_swap_pkg::cam_pack_t cam_pack,
    input  logic                     trig,
    input  logic                     read_en,
    output logic                     aquire,
    output line_swap_pkg::byte_t     cam_data,
    output line_swap_pkg::row_t      cam_row,
    output logic                     busy,
    output logic                     error
);
    import line_swap_pkg::*;

    localparam int NBYTES   = 3 * H_ACT;
    localparam int ADDR_W   = $clog2(NBYTES);
    localparam int COL_LSB  = `LSB_ROW_W;
    localparam int FLAG_LSB = COL_LSB + `LSB_COL_W;
    localparam int PIX_LSB  = FLAG_LSB + `LSB_FLAG_W;

    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_ARMED,
        BUF_CAPTURE,
        BUF_READOUT
    } buf_state_t;

    buf_state_t        state;
    pixel_t            pix_rgb;
    flags_t            pix_flags;
    col_t              pix_col;
    row_t              pix_row;
    col_t              pix_cnt;
    col_t              exp_col;
    logic              capturing;
    logic              pix_ok;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    byte_t             mem [NBYTES];

    assign pix_rgb   = cam_pack[PIX_LSB +: $bits(pixel_t)];
    assign pix_flags = cam_pack[FLAG_LSB +: `LSB_FLAG_W];
    assign pix_col   = cam_pack[COL_LSB +: `LSB_COL_W];
    assign pix_row   = cam_pack[0 +: `LSB_ROW_W];

    assign capturing = (state == BUF_ARMED) || (state == BUF_CAPTURE);
    assign exp_col   = (state == BUF_CAPTURE) ? pix_cnt : '0;  // Armed waits for column 0
    assign pix_ok    = capturing && pix_flags[0] && (pix_col == exp_col);
    assign wr_addr   = ADDR_W'(3 * exp_col);

    assign busy   = (state != BUF_IDLE);
    assign aquire = (state == BUF_READOUT);

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state   <= BUF_IDLE;
            pix_cnt <= '0;
            rd_addr <= '0;
            error   <= 1'b0;
        end else begin
            case (state)
                BUF_IDLE: begin
                    if (trig) begin
                        state <= BUF_ARMED;
                    end
                end
                BUF_ARMED, BUF_CAPTURE: begin
                    if (pix_ok) begin
                        pix_cnt <= exp_col + 1'b1;
                        if (exp_col == col_t'(H_ACT - 1)) begin
                            state <= BUF_READOUT;
                        end else begin
                            state <= BUF_CAPTURE;
                        end
                    end else if (state == BUF_CAPTURE && pix_flags[0]) begin
                        error <= 1'b1;                 // Column out of order restarts the line
                        state <= BUF_ARMED;
                    end
                end
                BUF_READOUT: begin
                    if (read_en) begin
                        if (rd_addr == ADDR_W'(NBYTES - 1)) begin
                            rd_addr <= '0;
                            state   <= BUF_IDLE;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= BUF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge rclk) begin
        if (pix_ok) begin
            mem[wr_addr]        <= pix_rgb[23:16];
            mem[wr_addr + 1'b1] <= pix_rgb[15:8];
            mem[wr_addr + 2'd2] <= pix_rgb[7:0];
        end
        if (pix_ok && state == BUF_ARMED) begin
            cam_row <= pix_row;                        // Row of the line being captured
        end
        if (aquire && read_en) begin
            cam_data <= mem[rd_addr];
        end
    end

endmodule : line_buffer

// File: rtl/line_swap_buffer.sv
`timescale 1ns/1ps
`include "line_swap_consts.svh"

module line_swap_buffer #(
    parameter int H_ACT = `LSB_H_ACT
) (
    input  logic                     rclk,
    input  logic                     rstn,
    input  logic                     trig,
    input  line_swap_pkg::cam_pack_t cam1_pack,
    input  line_swap_pkg::cam_pack_t cam2_pack,
    input  logic                     read_en,
    output logic                     aquire,
    output line_swap_pkg::byte_t     cam_data,
    output line_swap_pkg::row_t      cam_row,
    output line_swap_pkg::cam_id_t   cam_id,
    output logic                     error
);
    import line_swap_pkg::*;

    localparam int GAP_WAIT = `LSB_GAP_WAIT;
    localparam int GAP_W    = (GAP_WAIT > 0) ? $clog2(GAP_WAIT + 1) : 1;

    swap_state_t      state;
    logic             cam_sel;                          // 0 camera 1, 1 camera 2
    logic [GAP_W-1:0] gap_cnt;

    logic  cam1_trig, cam1_aquire, cam1_re, cam1_busy, cam1_err;
    logic  cam2_trig, cam2_aquire, cam2_re, cam2_busy, cam2_err;
    byte_t cam1_data, cam2_data;
    row_t  cam1_row, cam2_row;

    line_buffer #(.H_ACT(H_ACT)) u_line_buffer_1 (
        .rclk    (rclk),
        .rstn    (rstn),
        .cam_pack(cam1_pack),
        .trig    (cam1_trig),
        .read_en (cam1_re),
        .aquire  (cam1_aquire),
        .cam_data(cam1_data),
        .cam_row (cam1_row),
        .busy    (cam1_busy),
        .error   (cam1_err)
    );

    line_buffer #(.H_ACT(H_ACT)) u_line_buffer_2 (
        .rclk    (rclk),
        .rstn    (rstn),
        .cam_pack(cam2_pack),
        .trig    (cam2_trig),
        .read_en (cam2_re),
        .aquire  (cam2_aquire),
        .cam_data(cam2_data),
        .cam_row (cam2_row),
        .busy    (cam2_busy),
        .error   (cam2_err)
    );

    // Trigger held until the buffer reports busy
    assign cam1_trig = (state == TRIG_CAM1);
    assign cam2_trig = (state == TRIG_CAM2);

    assign cam1_re  = !cam_sel && read_en;
    assign cam2_re  = cam_sel && read_en;
    assign aquire   = cam_sel ? cam2_aquire : cam1_aquire;
    assign cam_data = cam_sel ? cam2_data : cam1_data;
    assign cam_row  = cam_sel ? cam2_row : cam1_row;
    assign cam_id   = cam_sel ? `LSB_CAM2_ID : `LSB_CAM1_ID;
    assign error    = cam1_err || cam2_err;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state   <= IDLE;
            cam_sel <= 1'b0;
            gap_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    cam_sel <= 1'b0;
                    if (trig) begin
                        state <= TRIG_CAM1;
                    end
                end
                TRIG_CAM1: begin
                    if (cam1_busy) begin
                        state <= WAIT_CAM1;
                    end
                end
                WAIT_CAM1: begin
                    if (!cam1_busy) begin
                        gap_cnt <= '0;
                        state   <= GAP;
                    end
                end
                GAP: begin
                    if (gap_cnt != GAP_W'(GAP_WAIT)) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end else begin
                        cam_sel <= 1'b1;
                        state   <= TRIG_CAM2;
                    end
                end
                TRIG_CAM2: begin
                    if (cam2_busy) begin
                        state <= WAIT_CAM2;
                    end
                end
                WAIT_CAM2: begin
                    if (!cam2_busy) begin
                        cam_sel <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule : line_swap_buffer

// File: rtl/line_reader.sv
`timescale 1ns/1ps
`include "line_swap_consts.svh"

module line_reader #(
    parameter int H_ACT = `LSB_H_ACT
) (
    input  logic                   rclk,
    input  logic                   rstn,
    input  logic                   aquire,
    input  line_swap_pkg::byte_t   cam_data,
    input  line_swap_pkg::row_t    cam_row,
    input  line_swap_pkg::cam_id_t cam_id,
    output logic                   read_en,
    output logic                   out_valid,
    output line_swap_pkg::byte_t   out_data,
    output line_swap_pkg::row_t    out_row,
    output line_swap_pkg::cam_id_t out_id,
    output logic                   out_last
);
    import line_swap_pkg::*;

    localparam int NBYTES = 3 * H_ACT;
    localparam int CNT_W  = $clog2(NBYTES);

    logic             rd_active;
    logic [CNT_W-1:0] byte_cnt;
    logic             last_byte;

    assign last_byte = (byte_cnt == CNT_W'(NBYTES - 1));
    assign read_en   = rd_active;
    assign out_data  = cam_data;                        // Buffer registers the byte a cycle later

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            rd_active <= 1'b0;
            byte_cnt  <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= rd_active;
            out_last  <= rd_active && last_byte;
            if (rd_active) begin
                if (last_byte) begin
                    rd_active <= 1'b0;
                    byte_cnt  <= '0;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end else if (aquire) begin
                rd_active <= 1'b1;                      // Start draining the offered line
                byte_cnt  <= '0;
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (rd_active && byte_cnt == '0) begin
            out_row <= cam_row;
            out_id  <= cam_id;
        end
    end

endmodule : line_reader

// File: rtl/dual_cam_line_top.sv
`timescale 1ns/1ps
`include "line_swap_consts.svh"

module dual_cam_line_top #(
    parameter int H_ACT = `LSB_H_ACT
) (
    input  logic                     rclk,
    input  logic                     rstn,
    input  logic                     trig,
    input  line_swap_pkg::cam_pack_t cam1_pack,
    input  line_swap_pkg::cam_pack_t cam2_pack,
    output logic                     out_valid,
    output line_swap_pkg::byte_t     out_data,
    output line_swap_pkg::row_t      out_row,
    output line_swap_pkg::cam_id_t   out_id,
    output logic                     out_last,
    output logic                     error
);
    import line_swap_pkg::*;

    logic    aquire;
    logic    read_en;
    byte_t   cam_data;
    row_t    cam_row;
    cam_id_t cam_id;

    line_swap_buffer #(.H_ACT(H_ACT)) u_line_swap_buffer (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .cam1_pack(cam1_pack),
        .cam2_pack(cam2_pack),
        .read_en  (read_en),
        .aquire   (aquire),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .cam_id   (cam_id),
        .error    (error)
    );

    line_reader #(.H_ACT(H_ACT)) u_line_reader (
        .rclk     (rclk),
        .rstn     (rstn),
        .aquire   (aquire),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .cam_id   (cam_id),
        .read_en  (read_en),
        .out_valid(out_valid),
        .out_data (out_data),
        .out_row  (out_row),
        .out_id   (out_id),
        .out_last (out_last)
    );

endmodule : dual_cam_line_top

// File: test/dual_cam_line_properties.sv
`timescale 1ns/1ps

module dual_cam_line_properties (
    input logic rclk,
    input logic rstn,
    input logic read_en,
    input logic aquire,
    input logic out_valid,
    input logic out_last,
    input logic error
);

    assert property (@(posedge rclk) disable iff (!rstn) read_en |-> aquire)
        else $error("read_en high while aquire is low");

    assert property (@(posedge rclk) disable iff (!rstn) out_last |-> out_valid)
        else $error("out_last high without out_valid");

    // Sticky error
    assert property (@(posedge rclk) disable iff (!rstn) $past(error) |-> error)
        else $error("error fell while out of reset");

endmodule : dual_cam_line_properties

bind dual_cam_line_top dual_cam_line_properties u_props (
    .rclk     (rclk),
    .rstn     (rstn),
    .read_en  (read_en),
    .aquire   (aquire),
    .out_valid(out_valid),
    .out_last (out_last),
    .error    (error)
);

// File: test/dual_cam_line_tb.sv
`timescale 1ns/1ps
`include "line_swap_consts.svh"

module dual_cam_line_tb;
    import line_swap_pkg::*;

    localparam int H        = `LSB_H_ACT;
    localparam int NB       = 3 * H;
    localparam int GAP      = `LSB_GAP_WAIT;
    localparam int NTRIG    = 4;
    localparam int MAXL     = 256;
    localparam int LINE_PER = 3 * H + 4;                 // Worst case cycles per camera line
    localparam int WD_CYC   = 2 * NTRIG * (2 * LINE_PER + 6 * H + GAP) + 20;

    logic      rclk;
    logic      rstn;
    logic      trig;
    cam_pack_t cam1_pack;
    cam_pack_t cam2_pack;
    logic      out_valid;
    byte_t     out_data;
    row_t      out_row;
    cam_id_t   out_id;
    logic      out_last;
    logic      error;

    int     cyc;
    int     trig_cnt;
    int     trig_at [NTRIG];
    int     line_cnt;
    int     byte_idx;
    int     cur_cam;
    int     cur_line;
    int     cam1_end;
    bit     exp_err;
    bit     inject [2];
    int     inject_from [2];
    int     n_lines [2];
    int     search_from [2];
    int     line_start [2][MAXL];
    bit     line_bad [2][MAXL];
    row_t   line_row [2][MAXL];
    pixel_t line_pix [2][MAXL][H];

    dual_cam_line_top u_dual_cam_line_top (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .cam1_pack(cam1_pack),
        .cam2_pack(cam2_pack),
        .out_valid(out_valid),
        .out_data (out_data),
        .out_row  (out_row),
        .out_id   (out_id),
        .out_last (out_last),
        .error    (error)
    );

    initial begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;
    end

    always @(posedge rclk) cyc <= cyc + 1;

    task automatic stop_on_fail(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            stop_on_fail($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_row(input string name, input row_t got, input row_t exp);
        if (got !== exp) begin
            stop_on_fail($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input cam_id_t got, input cam_id_t exp);
        if (got !== exp) begin
            stop_on_fail($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_error(input string name, input logic got, input bit exp);
        if (got !== exp) begin
            stop_on_fail($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Expected byte of pixel idx/3 in R, G, B order
    function automatic byte_t ref_byte(input int cam, input int ln, input int idx);
        pixel_t p;
        p = line_pix[cam][ln][idx / 3];
        case (idx % 3)
            0:       return p[23:16];
            1:       return p[15:8];
            default: return p[7:0];
        endcase
    endfunction

    // First clean line whose column 0 is sampled once the buffer is armed
    task automatic find_line(input int cam, input int bnd, output int idx);
        int i;
        idx = -1;
        for (i = search_from[cam]; i < n_lines[cam] && idx < 0; i++) begin
            if (line_start[cam][i] >= bnd) begin
                if (line_bad[cam][i]) begin
                    exp_err = 1'b1;                      // Skipped column seen mid capture
                end else begin
                    idx = i;
                end
            end
        end
        if (idx < 0) begin
            stop_on_fail($sformatf("No sent line matches output line %0d", line_cnt));
        end
        search_from[cam] = idx + 1;
    endtask

    task automatic put_word(input int cam, input cam_pack_t w);
        @(negedge rclk);
        if (cam == 0) begin
            cam1_pack = w;
        end else begin
            cam2_pack = w;
        end
    endtask

    task automatic run_camera(input int cam);
        int     ln;
        int     c;
        int     k;
        bit     bad;
        pixel_t px;
        col_t   col;
        row_t   row;
        for (ln = 0; ln < MAXL; ln++) begin
            repeat ($urandom_range(3, 1)) put_word(cam, {24'h0, 4'h0, col_t'($urandom), 11'h0});
            row = row_t'(cam * 1024 + ln);
            bad = 1'b0;
            for (c = 0; c < H; c++) begin
                k = $urandom_range(2, 0);
                repeat (k) put_word(cam, {24'h0, 4'h0, col_t'(0), row});
                px = pixel_t'($urandom);
                if (c == 0) begin
                    @(negedge rclk);
                    bad = inject[cam] && (cyc + 1 >= inject_from[cam]);
                    if (bad) begin
                        inject[cam] = 1'b0;
                    end
                    line_start[cam][ln] = cyc + 1;
                    line_bad[cam][ln] = bad;
                    line_row[cam][ln] = row;
                    line_pix[cam][ln][c] = px;
                    n_lines[cam] = ln + 1;
                    if (cam == 0) begin
                        cam1_pack = {px, 4'b0001, col_t'(0), row};
                    end else begin
                        cam2_pack = {px, 4'b0001, col_t'(0), row};
                    end
                end else begin
                    line_pix[cam][ln][c] = px;
                    col = (bad && c >= 5) ? col_t'(c + 1) : col_t'(c);  // Column 5 skipped
                    put_word(cam, {px, 4'b0001, col, row});
                end
            end
        end
        put_word(cam, '0);
    endtask

    initial begin
        trig      = 1'b0;
        cam1_pack = '0;
        cam2_pack = '0;
        rstn      = 1'b0;
        cyc       = 0;
        trig_cnt  = 0;
        line_cnt  = 0;
        byte_idx  = 0;
        exp_err   = 1'b0;
        inject    = '{1'b0, 1'b0};
        inject_from = '{0, 0};
        n_lines     = '{0, 0};
        search_from = '{0, 0};
        void'($urandom(40));
        repeat (4) @(negedge rclk);
        rstn = 1'b1;
        check_error("out_valid", out_valid, 1'b0);
        check_error("out_last", out_last, 1'b0);
        check_error("error", error, 1'b0);
    end

    initial begin
        @(posedge rstn);
        run_camera(0);
    end

    initial begin
        @(posedge rstn);
        run_camera(1);
    end

    initial begin
        int k;
        @(posedge rstn);
        for (k = 0; k < NTRIG; k++) begin
            repeat (4) @(negedge rclk);
            @(negedge rclk);
            trig = 1'b1;
            trig_at[k] = cyc + 1;
            if (k == 1) begin
                inject[0] = 1'b1;
                inject_from[0] = cyc + 3;
            end
            trig_cnt = trig_cnt + 1;
            @(negedge rclk);
            trig = 1'b0;
            if (k % 2 == 0) begin
                repeat (20) @(negedge rclk);             // Camera 1 line still pending
            end else begin
                while (line_cnt < 2 * k + 1) @(negedge rclk);
                repeat (4) @(negedge rclk);              // Inside the gap before camera 2
            end
            trig = 1'b1;                                 // Sequence running so this strobe is dropped
            @(negedge rclk);
            trig = 1'b0;
            while (line_cnt < 2 * (k + 1)) @(negedge rclk);
        end
        repeat (100) @(negedge rclk);
        if (error === 1'b1 && exp_err) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_on_fail("Column skip did not set the sticky error");
        end
    end

    always @(negedge rclk) begin
        if (rstn && out_valid) begin
            if (line_cnt >= 2 * trig_cnt) begin
                stop_on_fail("Output byte seen with no line pending");
            end
            if (byte_idx == 0) begin
                cur_cam = line_cnt % 2;
                if (cur_cam == 0) begin
                    find_line(0, trig_at[line_cnt / 2] + 2, cur_line);
                end else begin
                    find_line(1, cam1_end + GAP + 4, cur_line);
                end
            end
            check_byte("out_data", out_data, ref_byte(cur_cam, cur_line, byte_idx));
            check_row("out_row", out_row, line_row[cur_cam][cur_line]);
            check_id("out_id", out_id, (cur_cam == 0) ? `LSB_CAM1_ID : `LSB_CAM2_ID);
            check_error("error", error, exp_err);
            check_error("out_last", out_last, byte_idx == NB - 1);
            if (byte_idx == NB - 1) begin
                byte_idx = 0;
                if (cur_cam == 0) begin
                    cam1_end = cyc;
                    if (line_cnt / 2 == 2) begin
                        inject[1] = 1'b1;
                        inject_from[1] = cyc + GAP + 4;
                    end
                end
                line_cnt = line_cnt + 1;
            end else begin
                byte_idx = byte_idx + 1;
            end
        end
    end

    initial begin
        #(WD_CYC * 100);
        stop_on_fail($sformatf("Timeout after %0d cycles with %0d lines out", WD_CYC, line_cnt));
    end

endmodule : dual_cam_line_tb

// File: sources.f
+incdir+include
rtl/line_swap_pkg.sv
rtl/line_buffer.sv
rtl/line_swap_buffer.sv
rtl/line_reader.sv
rtl/dual_cam_line_top.sv
test/dual_cam_line_properties.sv
test/dual_cam_line_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := dual_cam_line_tb
FILELIST  := sources.f
FLAGS     := --binary --timing -Wno-fatal
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
